/* common/bt_link_params.svh */
`ifndef BT_LINK_PARAMS_SVH
`define BT_LINK_PARAMS_SVH

// fabric cycles per uart bit
`define BT_BIT_CYCLES 8

// credits per source, same as arbiter buffer depth
`define BT_CREDITS 4

// number of sensor channels
`define BT_CHANNELS 4

// pending frames held inside each producer
`define BT_QUEUE_DEPTH 4

// header nibbles, low bits carry channel or state
`define BT_SENSOR_HDR 4'h5
`define BT_STATUS_HDR 4'hA

`endif

/* common/bt_data_pkg.sv */
`include "bt_link_params.svh"

package bt_data_pkg;

	// one byte on the serial line
	typedef logic [7:0] byte_t;

	// sensor channel index
	typedef logic [$clog2(`BT_CHANNELS)-1:0] channel_t;

	// counts 0 up to BT_CREDITS inclusive
	typedef logic [$clog2(`BT_CREDITS+1)-1:0] credit_t;

	// all channel values side by side, channel 0 in the low byte
	typedef byte_t [`BT_CHANNELS-1:0] sensor_bus_t;

	// one byte of a frame plus end marker
	typedef struct packed
	{
		byte_t data;
		logic  last;
	} frame_beat_t;

endpackage

/* common/bt_ctrl_pkg.sv */
package bt_ctrl_pkg;

	// frame producers behind the arbiter
	typedef enum logic
	{
		SRC_SENSOR = 1'b0,
		SRC_STATUS = 1'b1
	} src_id_t;

	// sensor frame sequencing
	typedef enum logic [1:0]
	{
		S_IDLE = 2'd0,
		S_HDR  = 2'd1,
		S_DATA = 2'd2
	} sampler_state_t;

	// arbiter grant fsm
	typedef enum logic
	{
		A_PICK = 1'b0,
		A_HOLD = 1'b1
	} arb_state_t;

	// 8N1 transmit fsm
	typedef enum logic [1:0]
	{
		T_IDLE  = 2'd0,
		T_START = 2'd1,
		T_BITS  = 2'd2,
		T_STOP  = 2'd3
	} ser_state_t;

endpackage

/* rtl/sensor_sampler.sv */
`include "bt_link_params.svh"

module sensor_sampler
(
	input  logic                     CLK1MHZ,
	input  logic                     resetn,
	input  logic                     sample_req,
	input  bt_data_pkg::channel_t    sample_sel,
	input  bt_data_pkg::sensor_bus_t sensor_values,
	output logic                     sample_ready,
	output bt_data_pkg::frame_beat_t beat,
	output logic                     beat_valid,
	input  logic                     credit_return
);
	import bt_data_pkg::*;
	import bt_ctrl_pkg::*;

	localparam int PTR_W = $clog2(`BT_QUEUE_DEPTH);

	// request queue, channel and value captured together
	channel_t q_ch [`BT_QUEUE_DEPTH];
	byte_t    q_val [`BT_QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   q_count;

	credit_t        credits;
	sampler_state_t state;
	channel_t       cur_ch;
	byte_t          cur_val;
	logic           accept;
	logic           pop;
	logic           send;

	assign sample_ready = (q_count != `BT_QUEUE_DEPTH);
	assign accept       = sample_req && sample_ready;
	// fsm takes the oldest entry once idle
	assign pop          = (state == S_IDLE) && (q_count != '0);
	// a beat goes out only with a credit in hand
	assign send         = ((state == S_HDR) || (state == S_DATA)) && (credits != '0);

	// queue storage and current frame payload
	always_ff @(posedge CLK1MHZ)
	begin
		if (accept)
		begin
			q_ch[wr_ptr]  <= sample_sel;
			q_val[wr_ptr] <= sensor_values[sample_sel];
		end
		if (pop)
		begin
			cur_ch  <= q_ch[rd_ptr];
			cur_val <= q_val[rd_ptr];
		end
		// header first, then the sampled value closes the frame
		if (state == S_HDR)
		begin
			beat.data <= byte_t'({`BT_SENSOR_HDR, 4'(cur_ch)});
			beat.last <= 1'b0;
		end
		else
		begin
			beat.data <= cur_val;
			beat.last <= 1'b1;
		end
	end

	always_ff @(posedge CLK1MHZ or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			q_count    <= '0;
			credits    <= credit_t'(`BT_CREDITS);
			state      <= S_IDLE;
			beat_valid <= 1'b0;
		end
		else
		begin
			if (accept)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			q_count    <= q_count + (PTR_W+1)'(accept) - (PTR_W+1)'(pop);
			credits    <= credits + credit_t'(credit_return) - credit_t'(send);
			beat_valid <= send;
			case (state)
				S_IDLE:
					if (pop)
						state <= S_HDR;
				S_HDR:
					if (send)
						state <= S_DATA;
				S_DATA:
					if (send)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

endmodule

/* rtl/status_reporter.sv */
`include "bt_link_params.svh"

module status_reporter
(
	input  logic                     CLK1MHZ,
	input  logic                     resetn,
	input  logic                     bt_state,
	output bt_data_pkg::frame_beat_t beat,
	output logic                     beat_valid,
	input  logic                     credit_return
);
	import bt_data_pkg::*;

	localparam int PTR_W = $clog2(`BT_QUEUE_DEPTH);

	// two stage resync plus last seen level
	logic sync_1;
	logic sync_2;
	logic state_q;
	logic changed;

	logic q_state [`BT_QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_idx;
	logic [PTR_W:0]   q_count;
	logic             q_full;
	logic             push;
	credit_t          credits;
	logic             send;

	assign changed = sync_2 ^ state_q;
	assign q_full  = (q_count == `BT_QUEUE_DEPTH);
	// full queue, new edge replaces the youngest entry
	assign push    = changed && !q_full;
	assign wr_idx  = q_full ? (wr_ptr - 1'b1) : wr_ptr;
	assign send    = (q_count != '0) && (credits != '0);

	always_ff @(posedge CLK1MHZ)
	begin
		if (changed)
			q_state[wr_idx] <= sync_2;
		// single byte frame, state in bit 0
		beat.data <= byte_t'({`BT_STATUS_HDR, 3'b000, q_state[rd_ptr]});
		beat.last <= 1'b1;
	end

	always_ff @(posedge CLK1MHZ or negedge resetn)
	begin
		if (!resetn)
		begin
			sync_1     <= 1'b0;
			sync_2     <= 1'b0;
			state_q    <= 1'b0;
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			q_count    <= '0;
			credits    <= credit_t'(`BT_CREDITS);
			beat_valid <= 1'b0;
		end
		else
		begin
			sync_1  <= bt_state;
			sync_2  <= sync_1;
			state_q <= sync_2;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (send)
				rd_ptr <= rd_ptr + 1'b1;
			q_count    <= q_count + (PTR_W+1)'(push) - (PTR_W+1)'(send);
			credits    <= credits + credit_t'(credit_return) - credit_t'(send);
			beat_valid <= send;
		end
	end

endmodule

/* uart_tx/tx_arbiter.sv */
`include "bt_link_params.svh"

module tx_arbiter
(
	input  logic                     CLK1MHZ,
	input  logic                     resetn,
	input  bt_data_pkg::frame_beat_t sensor_beat,
	input  logic                     sensor_valid,
	output logic                     sensor_credit,
	input  bt_data_pkg::frame_beat_t status_beat,
	input  logic                     status_valid,
	output logic                     status_credit,
	output bt_data_pkg::frame_beat_t out_beat,
	output logic                     out_valid,
	input  logic                     out_ready
);
	import bt_data_pkg::*;
	import bt_ctrl_pkg::*;

	localparam int PTR_W = $clog2(`BT_CREDITS);

	// one credit-sized buffer per source
	frame_beat_t      buf_mem [2][`BT_CREDITS];
	logic [PTR_W-1:0] wr_ptr [2];
	logic [PTR_W-1:0] rd_ptr [2];
	credit_t          fill [2];
	frame_beat_t      in_beat [2];
	logic             in_valid [2];
	logic             pop [2];

	arb_state_t state;
	src_id_t    grant;
	src_id_t    last_grant;
	src_id_t    other;
	src_id_t    pick;
	logic       pick_any;
	logic       fire;

	assign in_beat[SRC_SENSOR]  = sensor_beat;
	assign in_beat[SRC_STATUS]  = status_beat;
	assign in_valid[SRC_SENSOR] = sensor_valid;
	assign in_valid[SRC_STATUS] = status_valid;

	// granted source drives the serializer while it has data
	assign out_valid = (state == A_HOLD) && (fill[grant] != '0);
	assign out_beat  = buf_mem[grant][rd_ptr[grant]];
	assign fire      = out_valid && out_ready;
	assign pop[SRC_SENSOR] = fire && (grant == SRC_SENSOR);
	assign pop[SRC_STATUS] = fire && (grant == SRC_STATUS);

	// round robin, the source not served last goes first
	assign other = (last_grant == SRC_SENSOR) ? SRC_STATUS : SRC_SENSOR;
	always_comb
	begin
		pick     = last_grant;
		pick_any = 1'b0;
		if (fill[other] != '0)
		begin
			pick     = other;
			pick_any = 1'b1;
		end
		else if (fill[last_grant] != '0)
			pick_any = 1'b1;
	end

	always_ff @(posedge CLK1MHZ)
	begin
		for (int s = 0; s < 2; s++)
			if (in_valid[s])
				buf_mem[s][wr_ptr[s]] <= in_beat[s];
	end

	always_ff @(posedge CLK1MHZ or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int s = 0; s < 2; s++)
			begin
				wr_ptr[s] <= '0;
				rd_ptr[s] <= '0;
				fill[s]   <= '0;
			end
			state         <= A_PICK;
			grant         <= SRC_SENSOR;
			last_grant    <= SRC_STATUS;
			sensor_credit <= 1'b0;
			status_credit <= 1'b0;
		end
		else
		begin
			for (int s = 0; s < 2; s++)
			begin
				if (in_valid[s])
					wr_ptr[s] <= wr_ptr[s] + 1'b1;
				if (pop[s])
					rd_ptr[s] <= rd_ptr[s] + 1'b1;
				fill[s] <= fill[s] + credit_t'(in_valid[s]) - credit_t'(pop[s]);
			end
			// each forwarded beat frees one slot for its producer
			sensor_credit <= pop[SRC_SENSOR];
			status_credit <= pop[SRC_STATUS];
			case (state)
				A_PICK:
					if (pick_any)
					begin
						grant <= pick;
						state <= A_HOLD;
					end
				A_HOLD:
					// frame ends when its last byte leaves
					if (fire && out_beat.last)
					begin
						last_grant <= grant;
						state      <= A_PICK;
					end
				default:
					state <= A_PICK;
			endcase
		end
	end

endmodule

/* uart_tx/uart_serializer.sv */
`include "bt_link_params.svh"

module uart_serializer
(
	input  logic                     CLK1MHZ,
	input  logic                     resetn,
	input  bt_data_pkg::frame_beat_t in_beat,
	input  logic                     in_valid,
	output logic                     in_ready,
	output logic                     txd,
	output logic                     sending_complete
);
	import bt_data_pkg::*;
	import bt_ctrl_pkg::*;

	localparam int CYC_W = $clog2(`BT_BIT_CYCLES);

	ser_state_t       state;
	logic [CYC_W-1:0] cyc_cnt;
	logic [2:0]       bit_idx;
	byte_t            shift_reg;
	logic             last_q;
	logic             bit_tick;

	// one new byte per idle slot
	assign in_ready = (state == T_IDLE);
	// end of the current bit period
	assign bit_tick = (cyc_cnt == CYC_W'(`BT_BIT_CYCLES - 1));

	always_ff @(posedge CLK1MHZ or negedge resetn)
	begin
		if (!resetn)
		begin
			state            <= T_IDLE;
			cyc_cnt          <= '0;
			bit_idx          <= '0;
			txd              <= 1'b1;
			sending_complete <= 1'b0;
		end
		else
		begin
			sending_complete <= 1'b0;
			cyc_cnt          <= bit_tick ? '0 : cyc_cnt + 1'b1;
			case (state)
				T_IDLE:
				begin
					cyc_cnt <= '0;
					if (in_valid)
					begin
						// start bit begins next cycle
						txd   <= 1'b0;
						state <= T_START;
					end
				end
				T_START:
					if (bit_tick)
					begin
						bit_idx <= '0;
						txd     <= shift_reg[0];
						state   <= T_BITS;
					end
				T_BITS:
					if (bit_tick)
					begin
						if (bit_idx == 3'd7)
						begin
							txd   <= 1'b1;
							state <= T_STOP;
						end
						else
						begin
							bit_idx <= bit_idx + 1'b1;
							txd     <= shift_reg[1];
						end
					end
				T_STOP:
					if (bit_tick)
					begin
						// pulse lands in the first cycle after the stop bit
						sending_complete <= last_q;
						state            <= T_IDLE;
					end
				default:
					state <= T_IDLE;
			endcase
		end
	end

	// data byte, lsb first
	always_ff @(posedge CLK1MHZ)
	begin
		if (in_valid && in_ready)
		begin
			shift_reg <= in_beat.data;
			last_q    <= in_beat.last;
		end
		else if ((state == T_BITS) && bit_tick)
			shift_reg <= shift_reg >> 1;
	end

endmodule

/* rtl/bt_link_top.sv */
module bt_link_top
(
	input  logic                     CLK1MHZ,
	input  logic                     resetn,
	input  logic                     sample_req,
	input  bt_data_pkg::channel_t    sample_sel,
	input  bt_data_pkg::sensor_bus_t sensor_values,
	input  logic                     bt_state,
	output logic                     sample_ready,
	output logic                     txd,
	output logic                     sending_complete
);
	import bt_data_pkg::*;

	// producer side links
	frame_beat_t sensor_beat;
	logic        sensor_valid;
	logic        sensor_credit;
	frame_beat_t status_beat;
	logic        status_valid;
	logic        status_credit;

	// arbiter to serializer
	frame_beat_t arb_beat;
	logic        arb_valid;
	logic        ser_ready;

	sensor_sampler u_sensor_sampler
	(
		.CLK1MHZ       (CLK1MHZ),
		.resetn        (resetn),
		.sample_req    (sample_req),
		.sample_sel    (sample_sel),
		.sensor_values (sensor_values),
		.sample_ready  (sample_ready),
		.beat          (sensor_beat),
		.beat_valid    (sensor_valid),
		.credit_return (sensor_credit)
	);

	status_reporter u_status_reporter
	(
		.CLK1MHZ       (CLK1MHZ),
		.resetn        (resetn),
		.bt_state      (bt_state),
		.beat          (status_beat),
		.beat_valid    (status_valid),
		.credit_return (status_credit)
	);

	tx_arbiter u_tx_arbiter
	(
		.CLK1MHZ       (CLK1MHZ),
		.resetn        (resetn),
		.sensor_beat   (sensor_beat),
		.sensor_valid  (sensor_valid),
		.sensor_credit (sensor_credit),
		.status_beat   (status_beat),
		.status_valid  (status_valid),
		.status_credit (status_credit),
		.out_beat      (arb_beat),
		.out_valid     (arb_valid),
		.out_ready     (ser_ready)
	);

	uart_serializer u_uart_serializer
	(
		.CLK1MHZ          (CLK1MHZ),
		.resetn           (resetn),
		.in_beat          (arb_beat),
		.in_valid         (arb_valid),
		.in_ready         (ser_ready),
		.txd              (txd),
		.sending_complete (sending_complete)
	);

endmodule

/* sim/tb_bt_link.sv */
`include "bt_link_params.svh"

module tb_bt_link;
	import bt_data_pkg::*;

	localparam int BIT_CYC        = `BT_BIT_CYCLES;
	localparam int BYTE_CYC       = 10 * BIT_CYC;
	localparam int SENSOR_REQS    = 24;
	localparam int STATUS_TOGGLES = 8;
	// spacing keeps the status queue from ever overflowing
	localparam int TOG_GAP_MIN    = 4 * BYTE_CYC;
	localparam int TOG_GAP_SPAN   = 256;
	localparam int REQ_PAUSE_MAX  = 100 + 255;
	localparam int TOTAL_FRAMES   = 1 + SENSOR_REQS + STATUS_TOGGLES;
	localparam int CYCLE_LIMIT    = TOTAL_FRAMES * 2 * BYTE_CYC
		+ STATUS_TOGGLES * (TOG_GAP_MIN + TOG_GAP_SPAN)
		+ SENSOR_REQS * REQ_PAUSE_MAX + 1000;

	logic        CLK1MHZ;
	logic        resetn;
	logic        sample_req;
	channel_t    sample_sel;
	sensor_bus_t sensor_values;
	logic        bt_state;
	logic        sample_ready;
	logic        txd;
	logic        sending_complete;

	integer seed;
	integer error_count;
	integer errs;
	integer tests_run;
	integer tests_failed;
	integer cycle_count;
	integer pulse_count;
	integer frames_decoded;
	integer sensor_accepted;
	integer hdr_decoded;

	// expected frames with the header in the upper byte of a sensor entry
	logic [15:0] sensor_q [$];
	logic [7:0]  status_q [$];

	// decoder state
	logic  line_samples [BYTE_CYC];
	logic  prev_txd;
	logic  busy;
	logic  expect_data;
	logic  is_last;
	logic  framing_ok;
	byte_t rx_byte;

	bt_link_top u_bt_link_top
	(
		.CLK1MHZ          (CLK1MHZ),
		.resetn           (resetn),
		.sample_req       (sample_req),
		.sample_sel       (sample_sel),
		.sensor_values    (sensor_values),
		.bt_state         (bt_state),
		.sample_ready     (sample_ready),
		.txd              (txd),
		.sending_complete (sending_complete)
	);

	initial
	begin
		CLK1MHZ = 1'b0;
		forever #5 CLK1MHZ = ~CLK1MHZ;
	end

	// run limit
	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge CLK1MHZ);
			cycle_count = cycle_count + 1;
		end
		$display("timeout: no result after %0d clock cycles", CYCLE_LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	end

	task check_value(input string name, input logic [15:0] got, input logic [15:0] expected);
		begin
			if (got !== expected)
			begin
				$display("** Error: %s is %h, expected %h (cycle %0d)", name, got, expected,
					cycle_count);
				error_count = error_count + 1;
			end
		end
	endtask

	task note_failure(input string msg);
		begin
			$display("error: %s (cycle %0d)", msg, cycle_count);
			error_count = error_count + 1;
		end
	endtask

	task finish_test(input string name, input integer errs_before);
		begin
			tests_run = tests_run + 1;
			if (error_count == errs_before)
				$display("test %s: pass", name);
			else
			begin
				tests_failed = tests_failed + 1;
				$display("test %s: fail, %0d errors", name, error_count - errs_before);
			end
		end
	endtask

	// first sample is the negedge where the start edge was seen
	task receive_byte(output byte_t data, output logic ok);
		logic mid;
		begin
			ok = 1'b1;
			line_samples[0] = txd;
			for (int k = 1; k < BYTE_CYC; k++)
			begin
				@(negedge CLK1MHZ);
				line_samples[k] = txd;
			end
			for (int b = 0; b < 10; b++)
			begin
				mid = line_samples[b * BIT_CYC + BIT_CYC / 2];
				// whole bit time must hold one level
				for (int c = 0; c < BIT_CYC; c++)
					if (line_samples[b * BIT_CYC + c] !== mid)
						ok = 1'b0;
				if ((b >= 1) && (b <= 8))
					data[b - 1] = mid;
			end
			check_value("txd start bit", line_samples[BIT_CYC / 2], 16'h0);
			check_value("txd stop bit", line_samples[9 * BIT_CYC + BIT_CYC / 2], 16'h1);
		end
	endtask

	task classify_byte(input byte_t data);
		logic [15:0] exp_frame;
		begin
			is_last = 1'b1;
			if (expect_data)
			begin
				// byte right after a header closes that sensor frame
				exp_frame = sensor_q.pop_front();
				check_value("sensor data byte", data, exp_frame[7:0]);
				expect_data = 1'b0;
				frames_decoded = frames_decoded + 1;
			end
			else if (data[7:4] == `BT_SENSOR_HDR)
			begin
				is_last = 1'b0;
				if (sensor_q.size() == 0)
					note_failure("sensor header on txd with no request outstanding");
				else
				begin
					check_value("sensor header byte", data, sensor_q[0][15:8]);
					expect_data = 1'b1;
					hdr_decoded = hdr_decoded + 1;
				end
			end
			else if (data[7:4] == `BT_STATUS_HDR)
			begin
				if (status_q.size() == 0)
					note_failure("status byte on txd with no state change outstanding");
				else
					check_value("status byte", data, status_q.pop_front());
				frames_decoded = frames_decoded + 1;
			end
			else
			begin
				is_last = 1'b0;
				note_failure($sformatf("byte %h on txd fits no frame type", data));
			end
		end
	endtask

	// line decoder
	initial
	begin
		prev_txd    = 1'b1;
		busy        = 1'b0;
		expect_data = 1'b0;
		forever
		begin
			@(negedge CLK1MHZ);
			if ((resetn === 1'b1) && (prev_txd === 1'b1) && (txd === 1'b0))
			begin
				busy = 1'b1;
				receive_byte(rx_byte, framing_ok);
				if (!framing_ok)
					note_failure("txd changed level inside a bit time");
				classify_byte(rx_byte);
				// done pulse sits in the cycle after the stop bit
				@(negedge CLK1MHZ);
				check_value("sending_complete", sending_complete, is_last);
				busy = 1'b0;
			end
			prev_txd = txd;
		end
	end

	// completion pulse counter
	initial
	begin
		forever
		begin
			@(negedge CLK1MHZ);
			if (sending_complete === 1'b1)
				pulse_count = pulse_count + 1;
		end
	end

	task issue_request;
		logic [31:0] rnd_vals;
		logic [31:0] rnd_sel;
		logic [1:0]  sel;
		logic [7:0]  val;
		begin
			rnd_vals = $random(seed);
			rnd_sel  = $random(seed);
			sel      = rnd_sel[1:0];
			@(negedge CLK1MHZ);
			while (sample_ready !== 1'b1)
			begin
				// full queue means at least a queue of frames not on the line yet
				if (sensor_accepted - hdr_decoded < `BT_QUEUE_DEPTH)
					note_failure($sformatf("sample_ready low with %0d sensor frames waiting",
						sensor_accepted - hdr_decoded));
				@(negedge CLK1MHZ);
			end
			@(posedge CLK1MHZ);
			sample_req    <= 1'b1;
			sample_sel    <= sel;
			sensor_values <= rnd_vals;
			@(posedge CLK1MHZ);
			sample_req <= 1'b0;
			// channel 0 sits in the low byte
			val = rnd_vals[{sel, 3'b000} +: 8];
			sensor_q.push_back({`BT_SENSOR_HDR, 2'b00, sel, val});
			sensor_accepted = sensor_accepted + 1;
		end
	endtask

	task send_bursts;
		logic [31:0] rnd;
		begin
			for (int i = 0; i < SENSOR_REQS; i++)
			begin
				rnd = $random(seed);
				// mostly back to back with an occasional long pause
				if (rnd[4:3] == 2'b00)
					repeat (100 + rnd[15:8]) @(posedge CLK1MHZ);
				else
					repeat (rnd[2:0]) @(posedge CLK1MHZ);
				issue_request();
			end
		end
	endtask

	task toggle_states;
		logic [31:0] rnd;
		logic        next_state;
		begin
			for (int i = 0; i < STATUS_TOGGLES; i++)
			begin
				rnd = $random(seed);
				repeat (TOG_GAP_MIN + rnd[7:0]) @(posedge CLK1MHZ);
				next_state = ~bt_state;
				bt_state <= next_state;
				status_q.push_back({`BT_STATUS_HDR, 3'b000, next_state});
			end
		end
	endtask

	task wait_drain;
		begin
			@(negedge CLK1MHZ);
			while ((sensor_q.size() != 0) || (status_q.size() != 0) || busy || expect_data)
				@(negedge CLK1MHZ);
		end
	endtask

	initial
	begin
		seed            = 77236;
		error_count     = 0;
		tests_run       = 0;
		tests_failed    = 0;
		pulse_count     = 0;
		frames_decoded  = 0;
		sensor_accepted = 0;
		hdr_decoded     = 0;
		resetn          = 1'b0;
		sample_req      = 1'b0;
		sample_sel      = '0;
		sensor_values   = '0;
		bt_state        = 1'b0;
		repeat (10) @(posedge CLK1MHZ);
		resetn <= 1'b1;

		// quiet line out of reset
		errs = error_count;
		for (int i = 0; i < 50; i++)
		begin
			@(negedge CLK1MHZ);
			check_value("txd", txd, 16'h1);
			check_value("sending_complete", sending_complete, 16'h0);
			check_value("sample_ready", sample_ready, 16'h1);
		end
		finish_test("reset idle line", errs);

		errs = error_count;
		issue_request();
		wait_drain();
		check_value("frames after one request", frames_decoded, 16'd1);
		finish_test("single sensor frame", errs);

		// sensor bursts with state changes on top
		errs = error_count;
		fork
			send_bursts();
			toggle_states();
		join
		wait_drain();
		check_value("frames decoded", frames_decoded, TOTAL_FRAMES);
		finish_test("mixed sensor and status traffic", errs);

		repeat (20) @(negedge CLK1MHZ);
		errs = error_count;
		check_value("sending_complete pulses", pulse_count, frames_decoded);
		finish_test("completion pulse count", errs);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+common
common/bt_data_pkg.sv
common/bt_ctrl_pkg.sv
rtl/sensor_sampler.sv
rtl/status_reporter.sv
uart_tx/tx_arbiter.sv
uart_tx/uart_serializer.sv
rtl/bt_link_top.sv
sim/tb_bt_link.sv
